// File: hdl/cave_defs.svh
/* Key scan codes, status word field positions, PLL reset hold count
   and reset synchronizer depth */
`ifndef CAVE_DEFS_SVH
`define CAVE_DEFS_SVH

// Reset timing
`define CAVE_PLL_RST_HOLD      256
`define CAVE_RST_SYNC_STAGES   2

// PS/2 set 2 make codes
`define CAVE_KEY_UP     8'h75
`define CAVE_KEY_DOWN   8'h72
`define CAVE_KEY_LEFT   8'h6B
`define CAVE_KEY_RIGHT  8'h74
`define CAVE_KEY_CTRL   8'h14
`define CAVE_KEY_ALT    8'h11
`define CAVE_KEY_SPACE  8'h29
`define CAVE_KEY_SHIFT  8'h12
`define CAVE_KEY_1      8'h16
`define CAVE_KEY_2      8'h1E
`define CAVE_KEY_5      8'h2E
`define CAVE_KEY_6      8'h36
`define CAVE_KEY_P      8'h4D
`define CAVE_KEY_R      8'h2D
`define CAVE_KEY_F      8'h2B
`define CAVE_KEY_D      8'h23
`define CAVE_KEY_G      8'h34
`define CAVE_KEY_A      8'h1C
`define CAVE_KEY_S      8'h1B
`define CAVE_KEY_Q      8'h15
`define CAVE_KEY_W      8'h1D

// Low bit of each field in the menu status word
`define CAVE_ST_RESET     0
`define CAVE_ST_ASPECT    1
`define CAVE_ST_ROTATE    3
`define CAVE_ST_FLIP      4
`define CAVE_ST_FX        5
`define CAVE_ST_COMPAT    8
`define CAVE_ST_SERVICE   9
`define CAVE_ST_LAYER     10
`define CAVE_ST_GAME      18
`define CAVE_ST_OFFSET_X  24
`define CAVE_ST_OFFSET_Y  28

`endif

// File: hdl/cave_pkg.sv
/* Shared vector types and PLL reset FSM state encoding */
`default_nettype none

package cave_pkg;

  // Menu status word from the HPS side
  typedef logic [31:0] status_t;

  // Joystick word
  // [3:0] right, left, down, up
  // [7:4] buttons 1 to 4
  // [8] start, [9] coin, [10] pause
  typedef logic [31:0] joystick_t;

  // PS/2 event word
  // [7:0] scan code, [9] pressed, [10] event toggle
  typedef logic [10:0] ps2_key_t;

  // One player's controls, same order as joystick bits 10..0
  typedef logic [10:0] player_ctrl_t;

  // Video aspect ratio term for HDMI
  typedef logic [12:0] aspect_t;

  // Screen position adjust, signed nibble as seen by the core
  typedef logic [3:0] offset_t;

  typedef logic [3:0] game_index_t;

  // Sprite, layer 0..2, row scroll, row select, sprite FB, system FB
  typedef logic [7:0] layer_en_t;

  // PLL reset stretcher
  typedef enum logic {
    PLL_RUN,
    PLL_HOLD
  } pll_rst_state_t;

endpackage

`default_nettype wire

// File: hdl/clock_reset_ctrl.sv
/* PLL lock-loss reset stretcher, system and CPU reset synchronizers */
`timescale 1ns/1ps
`default_nettype none
`include "cave_defs.svh"

module clock_reset_ctrl (
  input  wire  clk_sys,
  input  wire  RESET,
  input  logic pll_locked,
  input  logic cpu_reset_req,
  input  logic user_button,
  output logic rst_pll,
  output logic rst_sys,
  output logic rst_cpu
);

  //////////////////////////////////////////////////
  // PLL reset stretcher
  //////////////////////////////////////////////////

  cave_pkg::pll_rst_state_t pll_state;
  logic [7:0] hold_cnt;
  logic       lock_q;
  logic       lock_fall;

  // Lock seen high last cycle, low now
  assign lock_fall = lock_q & ~pll_locked;

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      pll_state <= cave_pkg::PLL_RUN;
      hold_cnt  <= 8'd0;
      lock_q    <= 1'b0;
    end else begin
      lock_q <= pll_locked;
      if (lock_fall) begin
        // Restart the hold on any new loss, even mid-hold
        pll_state <= cave_pkg::PLL_HOLD;
        hold_cnt  <= 8'(`CAVE_PLL_RST_HOLD - 1);
      end else if (pll_state == cave_pkg::PLL_HOLD) begin
        if (hold_cnt == 8'd0)
          pll_state <= cave_pkg::PLL_RUN;
        else
          hold_cnt <= hold_cnt - 8'd1;
      end
    end
  end

  assign rst_pll = (pll_state == cave_pkg::PLL_HOLD);

  //////////////////////////////////////////////////
  // Reset synchronizers
  //////////////////////////////////////////////////

  logic sys_rst_src;
  logic cpu_rst_src;
  logic [`CAVE_RST_SYNC_STAGES-1:0] sys_sync;
  logic [`CAVE_RST_SYNC_STAGES-1:0] cpu_sync;

  // CPU reset adds the menu reset and the user button
  assign sys_rst_src = RESET | ~pll_locked;
  assign cpu_rst_src = sys_rst_src | cpu_reset_req | user_button;

  // Assert at once, release after the chain drains
  always_ff @(posedge clk_sys or posedge sys_rst_src) begin
    if (sys_rst_src)
      sys_sync <= '1;
    else
      sys_sync <= {sys_sync[`CAVE_RST_SYNC_STAGES-2:0], 1'b0};
  end

  always_ff @(posedge clk_sys or posedge cpu_rst_src) begin
    if (cpu_rst_src)
      cpu_sync <= '1;
    else
      cpu_sync <= {cpu_sync[`CAVE_RST_SYNC_STAGES-2:0], 1'b0};
  end

  assign rst_sys = sys_sync[`CAVE_RST_SYNC_STAGES-1];
  assign rst_cpu = cpu_sync[`CAVE_RST_SYNC_STAGES-1];

  // Stretcher only starts on a sampled lock fall
  a_pll_rst_after_fall: assert property (@(posedge clk_sys) disable iff (RESET)
    $rose(rst_pll) |-> $past(lock_q) && !$past(pll_locked));

  // CPU is never running while the system is held
  a_cpu_covers_sys: assert property (@(posedge clk_sys) rst_sys |-> rst_cpu);

endmodule

`default_nettype wire

// File: hdl/player_controls.sv
/* PS/2 event strobe, held key table and joystick merge
   into the two player control words */
`timescale 1ns/1ps
`default_nettype none
`include "cave_defs.svh"

module player_controls (
  input  wire                     clk_sys,
  input  wire                     RESET,
  input  cave_pkg::ps2_key_t      ps2_key,
  input  cave_pkg::joystick_t     joystick_0,
  input  cave_pkg::joystick_t     joystick_1,
  output cave_pkg::player_ctrl_t  player_1,
  output cave_pkg::player_ctrl_t  player_2
);

  // Slots in the held key table
  localparam int K_UP    = 0;
  localparam int K_DOWN  = 1;
  localparam int K_LEFT  = 2;
  localparam int K_RIGHT = 3;
  localparam int K_CTRL  = 4;
  localparam int K_ALT   = 5;
  localparam int K_SPACE = 6;
  localparam int K_SHIFT = 7;
  localparam int K_1     = 8;
  localparam int K_5     = 9;
  localparam int K_P     = 10;
  localparam int K_R     = 11;
  localparam int K_F     = 12;
  localparam int K_D     = 13;
  localparam int K_G     = 14;
  localparam int K_A     = 15;
  localparam int K_S     = 16;
  localparam int K_Q     = 17;
  localparam int K_W     = 18;
  localparam int K_2     = 19;
  localparam int K_6     = 20;

  //////////////////////////////////////////////////
  // Event detect
  //////////////////////////////////////////////////

  logic        toggle_q;
  logic        key_strobe;
  logic        pressed;
  logic [7:0]  code;
  logic [20:0] key_sel;
  logic [20:0] key_held;

  assign pressed = ps2_key[9];
  assign code    = ps2_key[7:0];

  // Any edge of the toggle marks one new event
  assign key_strobe = toggle_q ^ ps2_key[10];

  // One-hot slot for the current scan code, zero if unknown
  always_comb begin
    key_sel = '0;
    case (code)
      `CAVE_KEY_UP:    key_sel[K_UP]    = 1'b1;
      `CAVE_KEY_DOWN:  key_sel[K_DOWN]  = 1'b1;
      `CAVE_KEY_LEFT:  key_sel[K_LEFT]  = 1'b1;
      `CAVE_KEY_RIGHT: key_sel[K_RIGHT] = 1'b1;
      `CAVE_KEY_CTRL:  key_sel[K_CTRL]  = 1'b1;
      `CAVE_KEY_ALT:   key_sel[K_ALT]   = 1'b1;
      `CAVE_KEY_SPACE: key_sel[K_SPACE] = 1'b1;
      `CAVE_KEY_SHIFT: key_sel[K_SHIFT] = 1'b1;
      `CAVE_KEY_1:     key_sel[K_1]     = 1'b1;
      `CAVE_KEY_5:     key_sel[K_5]     = 1'b1;
      `CAVE_KEY_P:     key_sel[K_P]     = 1'b1;
      `CAVE_KEY_R:     key_sel[K_R]     = 1'b1;
      `CAVE_KEY_F:     key_sel[K_F]     = 1'b1;
      `CAVE_KEY_D:     key_sel[K_D]     = 1'b1;
      `CAVE_KEY_G:     key_sel[K_G]     = 1'b1;
      `CAVE_KEY_A:     key_sel[K_A]     = 1'b1;
      `CAVE_KEY_S:     key_sel[K_S]     = 1'b1;
      `CAVE_KEY_Q:     key_sel[K_Q]     = 1'b1;
      `CAVE_KEY_W:     key_sel[K_W]     = 1'b1;
      `CAVE_KEY_2:     key_sel[K_2]     = 1'b1;
      `CAVE_KEY_6:     key_sel[K_6]     = 1'b1;
      default:         key_sel          = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Held key table
  //////////////////////////////////////////////////

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      toggle_q <= 1'b0;
      key_held <= '0;
    end else begin
      toggle_q <= ps2_key[10];
      // Selected slot takes the pressed bit, others keep state
      if (key_strobe)
        key_held <= (key_held & ~key_sel) | (key_sel & {21{pressed}});
    end
  end

  // Merge, bit order is pause, coin, start, buttons 4..1, up, down, left, right
  assign player_1 = {key_held[K_P], key_held[K_5], key_held[K_1],
                     key_held[K_SHIFT], key_held[K_SPACE], key_held[K_ALT], key_held[K_CTRL],
                     key_held[K_UP], key_held[K_DOWN], key_held[K_LEFT], key_held[K_RIGHT]}
                    | joystick_0[10:0];

  // No pause key for player 2
  assign player_2 = {1'b0, key_held[K_6], key_held[K_2],
                     key_held[K_W], key_held[K_Q], key_held[K_S], key_held[K_A],
                     key_held[K_R], key_held[K_F], key_held[K_D], key_held[K_G]}
                    | joystick_1[10:0];

  // Table only moves on an event
  a_keys_need_strobe: assert property (@(posedge clk_sys) disable iff (RESET)
    !key_strobe |=> $stable(key_held));

endmodule

`default_nettype wire

// File: hdl/option_decode.sv
/* Registered decode of the menu status word into video and core options */
`timescale 1ns/1ps
`default_nettype none
`include "cave_defs.svh"

module option_decode (
  input  wire                    clk_sys,
  input  wire                    RESET,
  input  cave_pkg::status_t      status,
  input  logic                   forced_scandoubler,
  output cave_pkg::aspect_t      video_arx,
  output cave_pkg::aspect_t      video_ary,
  output logic [1:0]             vga_sl,
  output logic                   scandoubler,
  output logic                   hq2x,
  output logic                   rotate,
  output logic                   flip,
  output logic                   compatibility,
  output logic                   service,
  output cave_pkg::offset_t      offset_x,
  output cave_pkg::offset_t      offset_y,
  output cave_pkg::layer_en_t    layer_enable,
  output cave_pkg::game_index_t  game_index
);

  //////////////////////////////////////////////////
  // Field extract
  //////////////////////////////////////////////////

  logic [1:0]        aspect_sel;
  logic              rotate_sel;
  logic [2:0]        fx;
  logic [2:0]        scan_level;
  cave_pkg::aspect_t arx_next;
  cave_pkg::aspect_t ary_next;

  assign aspect_sel = status[`CAVE_ST_ASPECT +: 2];
  assign rotate_sel = status[`CAVE_ST_ROTATE];
  assign fx         = status[`CAVE_ST_FX +: 3];

  // FX 0 none, 1 HQ2x, 2 and up CRT scanlines
  assign scan_level = (fx != 3'd0) ? fx - 3'd1 : 3'd0;

  // Original aspect is 4:3, portrait when rotated
  // Other settings pass through as ARC index with ary 0
  always_comb begin
    if (aspect_sel == 2'd0) begin
      arx_next = rotate_sel ? 13'd3 : 13'd4;
      ary_next = rotate_sel ? 13'd4 : 13'd3;
    end else begin
      arx_next = 13'(aspect_sel) - 13'd1;
      ary_next = 13'd0;
    end
  end

  //////////////////////////////////////////////////
  // Output registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      video_arx     <= '0;
      video_ary     <= '0;
      vga_sl        <= 2'd0;
      scandoubler   <= 1'b0;
      hq2x          <= 1'b0;
      rotate        <= 1'b0;
      flip          <= 1'b0;
      compatibility <= 1'b0;
      service       <= 1'b0;
      offset_x      <= '0;
      offset_y      <= '0;
      // Every layer shown out of reset
      layer_enable  <= '1;
      game_index    <= '0;
    end else begin
      video_arx     <= arx_next;
      video_ary     <= ary_next;
      vga_sl        <= scan_level[1:0];
      scandoubler   <= (fx != 3'd0) | forced_scandoubler;
      hq2x          <= (fx == 3'd1);
      rotate        <= rotate_sel;
      flip          <= status[`CAVE_ST_FLIP];
      compatibility <= status[`CAVE_ST_COMPAT];
      service       <= status[`CAVE_ST_SERVICE];
      offset_x      <= status[`CAVE_ST_OFFSET_X +: 4];
      offset_y      <= status[`CAVE_ST_OFFSET_Y +: 4];
      // Menu bits are disables
      layer_enable  <= ~status[`CAVE_ST_LAYER +: 8];
      game_index    <= status[`CAVE_ST_GAME +: 4];
    end
  end

endmodule

`default_nettype wire

// File: hdl/cave_frontend.sv
/* Control front end top level, resets, player controls and option decode */
`timescale 1ns/1ps
`default_nettype none
`include "cave_defs.svh"

module cave_frontend (
  input  wire                    clk_sys,
  input  wire                    RESET,
  // PLL and board inputs
  input  logic                   pll_locked,
  input  logic                   user_button,
  // From the HPS side
  input  cave_pkg::status_t      status,
  input  logic                   forced_scandoubler,
  input  cave_pkg::joystick_t    joystick_0,
  input  cave_pkg::joystick_t    joystick_1,
  input  cave_pkg::ps2_key_t     ps2_key,
  // Resets
  output logic                   rst_pll,
  output logic                   rst_sys,
  output logic                   rst_cpu,
  // Player controls
  output cave_pkg::player_ctrl_t player_1,
  output cave_pkg::player_ctrl_t player_2,
  // Video options
  output cave_pkg::aspect_t      video_arx,
  output cave_pkg::aspect_t      video_ary,
  output logic [1:0]             vga_sl,
  output logic                   scandoubler,
  output logic                   hq2x,
  output logic                   rotate,
  output logic                   flip,
  // Core options
  output logic                   compatibility,
  output logic                   service,
  output cave_pkg::offset_t      offset_x,
  output cave_pkg::offset_t      offset_y,
  output cave_pkg::layer_en_t    layer_enable,
  output cave_pkg::game_index_t  game_index
);

  //////////////////////////////////////////////////
  // Clock and reset
  //////////////////////////////////////////////////

  // Menu reset only restarts the CPU
  clock_reset_ctrl u_clock_reset_ctrl (
    .clk_sys       (clk_sys),
    .RESET         (RESET),
    .pll_locked    (pll_locked),
    .cpu_reset_req (status[`CAVE_ST_RESET]),
    .user_button   (user_button),
    .rst_pll       (rst_pll),
    .rst_sys       (rst_sys),
    .rst_cpu       (rst_cpu)
  );

  //////////////////////////////////////////////////
  // Controls and options
  //////////////////////////////////////////////////

  player_controls u_player_controls (
    .clk_sys    (clk_sys),
    .RESET      (RESET),
    .ps2_key    (ps2_key),
    .joystick_0 (joystick_0),
    .joystick_1 (joystick_1),
    .player_1   (player_1),
    .player_2   (player_2)
  );

  option_decode u_option_decode (
    .clk_sys            (clk_sys),
    .RESET              (RESET),
    .status             (status),
    .forced_scandoubler (forced_scandoubler),
    .video_arx          (video_arx),
    .video_ary          (video_ary),
    .vga_sl             (vga_sl),
    .scandoubler        (scandoubler),
    .hq2x               (hq2x),
    .rotate             (rotate),
    .flip               (flip),
    .compatibility      (compatibility),
    .service            (service),
    .offset_x           (offset_x),
    .offset_y           (offset_y),
    .layer_enable       (layer_enable),
    .game_index         (game_index)
  );

endmodule

`default_nettype wire

// File: testbench/tb_cave_frontend.sv
/* Front end testbench with clock, reset, stimulus tables,
   the value check task and the six tests */
`timescale 1ns/1ps
`default_nettype none
`include "cave_defs.svh"

module tb_cave_frontend;

  logic                   clk_sys;
  logic                   RESET;
  logic                   pll_locked;
  logic                   user_button;
  cave_pkg::status_t      status;
  logic                   forced_scandoubler;
  cave_pkg::joystick_t    joystick_0;
  cave_pkg::joystick_t    joystick_1;
  cave_pkg::ps2_key_t     ps2_key;
  logic                   rst_pll;
  logic                   rst_sys;
  logic                   rst_cpu;
  cave_pkg::player_ctrl_t player_1;
  cave_pkg::player_ctrl_t player_2;
  cave_pkg::aspect_t      video_arx;
  cave_pkg::aspect_t      video_ary;
  logic [1:0]             vga_sl;
  logic                   scandoubler;
  logic                   hq2x;
  logic                   rotate;
  logic                   flip;
  logic                   compatibility;
  logic                   service;
  cave_pkg::offset_t      offset_x;
  cave_pkg::offset_t      offset_y;
  cave_pkg::layer_en_t    layer_enable;
  cave_pkg::game_index_t  game_index;

  // Keyboard rows {code, pressed, player 1, player 2}
  logic [30:0]         kb_row [0:40];
  // Joystick rows and their player words with no key held
  cave_pkg::joystick_t joy_row0 [0:5];
  cave_pkg::joystick_t joy_row1 [0:5];
  logic [10:0]         joy_exp1 [0:5];
  logic [10:0]         joy_exp2 [0:5];
  // Option rows {status, forced_scandoubler}
  logic [32:0]         opt_row [0:5];
  // {arx, ary, sl, sd, hq2x, rotate, flip, compat, service, ox, oy, layers, game}
  logic [53:0]         opt_exp [0:5];

  int     errors;
  int     checks;
  int     test_err_base;
  int     cycles;
  int     i;
  int     pass;
  integer seed;

  cave_frontend u_cave_frontend (
    .clk_sys            (clk_sys),
    .RESET              (RESET),
    .pll_locked         (pll_locked),
    .user_button        (user_button),
    .status             (status),
    .forced_scandoubler (forced_scandoubler),
    .joystick_0         (joystick_0),
    .joystick_1         (joystick_1),
    .ps2_key            (ps2_key),
    .rst_pll            (rst_pll),
    .rst_sys            (rst_sys),
    .rst_cpu            (rst_cpu),
    .player_1           (player_1),
    .player_2           (player_2),
    .video_arx          (video_arx),
    .video_ary          (video_ary),
    .vga_sl             (vga_sl),
    .scandoubler        (scandoubler),
    .hq2x               (hq2x),
    .rotate             (rotate),
    .flip               (flip),
    .compatibility      (compatibility),
    .service            (service),
    .offset_x           (offset_x),
    .offset_y           (offset_y),
    .layer_enable       (layer_enable),
    .game_index         (game_index)
  );

  // 4 ns clock
  initial begin
    clk_sys = 1'b0;
    forever #2 clk_sys = ~clk_sys;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
    end
  endtask

  task automatic end_test(input string name);
    if (errors == test_err_base)
      $display("Test %s passed", name);
    else
      $display("Test %s failed, %0d mismatches", name, errors - test_err_base);
    test_err_base = errors;
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("TIMEOUT: %s was not seen within its cycle limit", what);
  endtask

  // Drive slot, 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_sys);
    #1;
  endtask

  // 0 system, 1 CPU, anything else PLL
  function automatic logic reset_level(input int which);
    case (which)
      0:       return rst_sys;
      1:       return rst_cpu;
      default: return rst_pll;
    endcase
  endfunction

  // Counts drive slots until the reset reaches the level
  task automatic wait_reset_level(input int which, input logic level, input int limit,
                                  input string what, output int count);
    count = 0;
    while (reset_level(which) !== level && count < limit) begin
      next_cycle();
      count++;
    end
    if (reset_level(which) !== level)
      report_timeout(what);
  endtask

  task automatic load_tables();
    // Arrow up, ctrl, 5, p for player 1; r, 6, d for player 2
    kb_row[0]  = {`CAVE_KEY_UP,    1'b1, 11'h008, 11'h000};
    kb_row[1]  = {`CAVE_KEY_CTRL,  1'b1, 11'h018, 11'h000};
    kb_row[2]  = {`CAVE_KEY_R,     1'b1, 11'h018, 11'h008};
    kb_row[3]  = {`CAVE_KEY_5,     1'b1, 11'h218, 11'h008};
    // Unknown code leaves both words alone
    kb_row[4]  = {8'h00,           1'b1, 11'h218, 11'h008};
    kb_row[5]  = {`CAVE_KEY_UP,    1'b0, 11'h210, 11'h008};
    kb_row[6]  = {`CAVE_KEY_P,     1'b1, 11'h610, 11'h008};
    kb_row[7]  = {`CAVE_KEY_6,     1'b1, 11'h610, 11'h208};
    kb_row[8]  = {`CAVE_KEY_D,     1'b1, 11'h610, 11'h20A};
    kb_row[9]  = {`CAVE_KEY_CTRL,  1'b0, 11'h600, 11'h20A};
    kb_row[10] = {`CAVE_KEY_5,     1'b0, 11'h400, 11'h20A};
    kb_row[11] = {`CAVE_KEY_P,     1'b0, 11'h000, 11'h20A};
    kb_row[12] = {`CAVE_KEY_R,     1'b0, 11'h000, 11'h202};
    kb_row[13] = {`CAVE_KEY_6,     1'b0, 11'h000, 11'h002};
    kb_row[14] = {`CAVE_KEY_D,     1'b0, 11'h000, 11'h000};
    // Remaining keys pressed in turn, then released in the same order
    kb_row[15] = {`CAVE_KEY_DOWN,  1'b1, 11'h004, 11'h000};
    kb_row[16] = {`CAVE_KEY_LEFT,  1'b1, 11'h006, 11'h000};
    kb_row[17] = {`CAVE_KEY_RIGHT, 1'b1, 11'h007, 11'h000};
    kb_row[18] = {`CAVE_KEY_ALT,   1'b1, 11'h027, 11'h000};
    kb_row[19] = {`CAVE_KEY_SPACE, 1'b1, 11'h067, 11'h000};
    kb_row[20] = {`CAVE_KEY_1,     1'b1, 11'h167, 11'h000};
    kb_row[21] = {`CAVE_KEY_F,     1'b1, 11'h167, 11'h004};
    kb_row[22] = {`CAVE_KEY_G,     1'b1, 11'h167, 11'h005};
    kb_row[23] = {`CAVE_KEY_A,     1'b1, 11'h167, 11'h015};
    kb_row[24] = {`CAVE_KEY_S,     1'b1, 11'h167, 11'h035};
    kb_row[25] = {`CAVE_KEY_Q,     1'b1, 11'h167, 11'h075};
    kb_row[26] = {`CAVE_KEY_W,     1'b1, 11'h167, 11'h0F5};
    kb_row[27] = {`CAVE_KEY_2,     1'b1, 11'h167, 11'h1F5};
    kb_row[28] = {`CAVE_KEY_DOWN,  1'b0, 11'h163, 11'h1F5};
    kb_row[29] = {`CAVE_KEY_LEFT,  1'b0, 11'h161, 11'h1F5};
    kb_row[30] = {`CAVE_KEY_RIGHT, 1'b0, 11'h160, 11'h1F5};
    kb_row[31] = {`CAVE_KEY_ALT,   1'b0, 11'h140, 11'h1F5};
    kb_row[32] = {`CAVE_KEY_SPACE, 1'b0, 11'h100, 11'h1F5};
    kb_row[33] = {`CAVE_KEY_1,     1'b0, 11'h000, 11'h1F5};
    kb_row[34] = {`CAVE_KEY_F,     1'b0, 11'h000, 11'h1F1};
    kb_row[35] = {`CAVE_KEY_G,     1'b0, 11'h000, 11'h1F0};
    kb_row[36] = {`CAVE_KEY_A,     1'b0, 11'h000, 11'h1E0};
    kb_row[37] = {`CAVE_KEY_S,     1'b0, 11'h000, 11'h1C0};
    kb_row[38] = {`CAVE_KEY_Q,     1'b0, 11'h000, 11'h180};
    kb_row[39] = {`CAVE_KEY_W,     1'b0, 11'h000, 11'h100};
    kb_row[40] = {`CAVE_KEY_2,     1'b0, 11'h000, 11'h000};
    for (int r = 0; r < 6; r++) begin
      joy_row0[r] = $random(seed);
      joy_row1[r] = $random(seed);
      joy_exp1[r] = joy_row0[r][10:0];
      joy_exp2[r] = joy_row1[r][10:0];
    end
    // Reset bit kept clear so the CPU reset stays quiet
    opt_row[0] = {32'h0000_0000, 1'b0};
    opt_exp[0] = {13'd4, 13'd3, 2'd0, 6'b000000, 4'h0, 4'h0, 8'hFF, 4'h0};
    opt_row[1] = {32'h0000_0028, 1'b0};
    opt_exp[1] = {13'd3, 13'd4, 2'd0, 6'b111000, 4'h0, 4'h0, 8'hFF, 4'h0};
    opt_row[2] = {32'h0000_0094, 1'b0};
    opt_exp[2] = {13'd1, 13'd0, 2'd3, 6'b100100, 4'h0, 4'h0, 8'hFF, 4'h0};
    opt_row[3] = {32'hC329_5706, 1'b1};
    opt_exp[3] = {13'd2, 13'd0, 2'd0, 6'b100011, 4'h3, 4'hC, 8'hAA, 4'hA};
    opt_row[4] = {32'h003F_FCE2, 1'b0};
    opt_exp[4] = {13'd0, 13'd0, 2'd2, 6'b100000, 4'h0, 4'h0, 8'h00, 4'hF};
    // Rotation ignored once an aspect is picked
    opt_row[5] = {32'h0000_000A, 1'b1};
    opt_exp[5] = {13'd0, 13'd0, 2'd0, 6'b101000, 4'h0, 4'h0, 8'hFF, 4'h0};
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  initial begin
    RESET              = 1'b1;
    pll_locked         = 1'b1;
    user_button        = 1'b0;
    status             = '0;
    forced_scandoubler = 1'b0;
    joystick_0         = '0;
    joystick_1         = '0;
    ps2_key            = '0;
    errors             = 0;
    checks             = 0;
    test_err_base      = 0;
    seed               = 32'h5bb3_f8d8;
    load_tables();

    // Test 1, reset state
    repeat (3) next_cycle();
    check_value("rst_sys", 32'(rst_sys), 32'd1);
    check_value("rst_cpu", 32'(rst_cpu), 32'd1);
    check_value("rst_pll", 32'(rst_pll), 32'd0);
    check_value("player_1", 32'(player_1), 32'd0);
    check_value("player_2", 32'(player_2), 32'd0);
    check_value("layer_enable", 32'(layer_enable), 32'hFF);
    repeat (2) next_cycle();
    RESET = 1'b0;
    check_value("rst_sys", 32'(rst_sys), 32'd1);
    check_value("rst_cpu", 32'(rst_cpu), 32'd1);
    wait_reset_level(0, 1'b0, 8, "rst_sys release after reset", cycles);
    check_value("rst_sys release cycles", 32'(cycles), 32'd2);
    check_value("rst_cpu", 32'(rst_cpu), 32'd0);
    end_test("reset state");

    // Test 2, keyboard events one per cycle
    for (i = 0; i < 41; i++) begin
      ps2_key = {~ps2_key[10], kb_row[i][22], 1'b0, kb_row[i][30:23]};
      next_cycle();
      check_value("player_1", 32'(player_1), 32'(kb_row[i][21:11]));
      check_value("player_2", 32'(player_2), 32'(kb_row[i][10:0]));
    end
    end_test("keyboard");

    // Test 3, joystick merge, second pass with shift held
    for (pass = 0; pass < 2; pass++) begin
      if (pass == 1) begin
        ps2_key = {~ps2_key[10], 1'b1, 1'b0, `CAVE_KEY_SHIFT};
        next_cycle();
      end
      for (i = 0; i < 6; i++) begin
        joystick_0 = joy_row0[i];
        joystick_1 = joy_row1[i];
        #1;
        check_value("player_1", 32'(player_1),
                    32'(joy_exp1[i] | ((pass == 1) ? 11'h080 : 11'h000)));
        check_value("player_2", 32'(player_2), 32'(joy_exp2[i]));
        next_cycle();
      end
    end
    ps2_key    = {~ps2_key[10], 1'b0, 1'b0, `CAVE_KEY_SHIFT};
    joystick_0 = '0;
    joystick_1 = '0;
    next_cycle();
    check_value("player_1", 32'(player_1), 32'd0);
    end_test("joystick merge");

    // Test 4, option decode one cycle after status
    for (i = 0; i < 6; i++) begin
      status             = opt_row[i][32:1];
      forced_scandoubler = opt_row[i][0];
      next_cycle();
      check_value("video_arx", 32'(video_arx), 32'(opt_exp[i][53:41]));
      check_value("video_ary", 32'(video_ary), 32'(opt_exp[i][40:28]));
      check_value("vga_sl", 32'(vga_sl), 32'(opt_exp[i][27:26]));
      check_value("scandoubler", 32'(scandoubler), 32'(opt_exp[i][25]));
      check_value("hq2x", 32'(hq2x), 32'(opt_exp[i][24]));
      check_value("rotate", 32'(rotate), 32'(opt_exp[i][23]));
      check_value("flip", 32'(flip), 32'(opt_exp[i][22]));
      check_value("compatibility", 32'(compatibility), 32'(opt_exp[i][21]));
      check_value("service", 32'(service), 32'(opt_exp[i][20]));
      check_value("offset_x", 32'(offset_x), 32'(opt_exp[i][19:16]));
      check_value("offset_y", 32'(offset_y), 32'(opt_exp[i][15:12]));
      check_value("layer_enable", 32'(layer_enable), 32'(opt_exp[i][11:4]));
      check_value("game_index", 32'(game_index), 32'(opt_exp[i][3:0]));
    end
    status             = '0;
    forced_scandoubler = 1'b0;
    end_test("option decode");

    // Test 5, PLL lock loss
    pll_locked = 1'b0;
    wait_reset_level(2, 1'b1, 4, "rst_pll rise", cycles);
    check_value("rst_pll rise cycles", 32'(cycles), 32'd1);
    check_value("rst_sys", 32'(rst_sys), 32'd1);
    wait_reset_level(2, 1'b0, 300, "rst_pll fall", cycles);
    check_value("rst_pll high cycles", 32'(cycles), 32'd256);
    check_value("rst_sys", 32'(rst_sys), 32'd1);
    pll_locked = 1'b1;
    wait_reset_level(0, 1'b0, 8, "rst_sys release after lock", cycles);
    check_value("rst_sys release cycles", 32'(cycles), 32'd2);
    check_value("rst_cpu", 32'(rst_cpu), 32'd0);
    check_value("rst_pll", 32'(rst_pll), 32'd0);
    end_test("PLL lock loss");

    // Test 6, menu reset bit then user button
    for (pass = 0; pass < 2; pass++) begin
      if (pass == 0)
        status = 32'h0000_0001;
      else
        user_button = 1'b1;
      next_cycle();
      check_value("rst_cpu", 32'(rst_cpu), 32'd1);
      check_value("rst_sys", 32'(rst_sys), 32'd0);
      repeat (3) next_cycle();
      check_value("rst_cpu", 32'(rst_cpu), 32'd1);
      status      = '0;
      user_button = 1'b0;
      wait_reset_level(1, 1'b0, 8, "rst_cpu release", cycles);
      check_value("rst_cpu release cycles", 32'(cycles), 32'd2);
    end
    end_test("CPU reset only");

    $display("Checks run: %0d, mismatches: %0d", checks, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+hdl
hdl/cave_pkg.sv
hdl/clock_reset_ctrl.sv
hdl/player_controls.sv
hdl/option_decode.sv
hdl/cave_frontend.sv
testbench/tb_cave_frontend.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of the front end testbench
# The run fails when the log holds the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f sources.f --top-module tb_cave_frontend \
  --Mdir obj_dir -o sim_cave \
  && ./obj_dir/sim_cave > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "Finished with errors" sim.log && { echo "Simulation failed"; exit 1; }
echo "Simulation passed"
exit 0
